/* hw/soc_consts.svh */
// Build-time constants for the peripheral subsystem.
// Widths, device table size, INFO values and the address map.
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Data and address widths.
`define SOC_ARCHBITSZ 32
`define SOC_ADDRBITSZ 30

// Device table slots, RAM included.
`define SOC_DEVMAPCNT 4

// Values returned by the INFO queries.
`define SOC_VERSION    32'h0000_0103
`define SOC_RAMCACHESZ 32'd256
`define SOC_PRELDRADDR 32'h0000_2000
`define SOC_ID         32'h5050_0001

// Address map.
`define SOC_BLOCKDEVMAPSZ 512 // Slot 0 window in bytes.
`define SOC_RAM_BASE      32'h0000_1000 // First RAM device.
`define SOC_RAM_WORDS     64

`endif

/* hw/soc_pkg.sv */
// Shared types for the peripheral subsystem.
// Bus opcodes, device table selectors and the request, response and slot structs.
`include "soc_consts.svh"

package soc_pkg;

	// Bus opcodes, as encoded on the master port.
	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi_op_e;

	typedef enum logic [`SOC_ARCHBITSZ-1:0] {
		INFO_VERSION    = 0,
		INFO_RAMCACHESZ = 1,
		INFO_RSTSTATE   = 2,
		INFO_PRELDRADDR = 3,
		INFO_SOCID      = 4
	} devtbl_info_e;

	typedef enum logic [`SOC_ARCHBITSZ-1:0] {
		ACT_PWROFF = 0,
		ACT_WRESET = 1,
		ACT_CRESET = 2,
		ACT_RRESET = 3
	} devtbl_action_e;

	typedef struct packed {
		pi_op_e                           op;
		logic [`SOC_ADDRBITSZ-1:0]        addr; // Word address.
		logic [`SOC_ARCHBITSZ-1:0]        data;
		logic [(`SOC_ARCHBITSZ/8)-1:0]    sel;
	} pi_req_t;

	typedef struct packed {
		logic [`SOC_ARCHBITSZ-1:0] data;
		logic                      rdy;
	} pi_rsp_t;

	typedef struct packed {
		logic [`SOC_ARCHBITSZ-1:0] id; // 1 means RAM.
		logic [`SOC_ARCHBITSZ-1:0] mapsz; // In bytes.
		logic                      useintr;
	} dev_desc_t;

endpackage

/* hw/pi_router.sv */
// Address router between the master port, the device table and the RAM.
// Rebases each request into its target window and returns the chosen response.
`timescale 1ns/1ps
`include "soc_consts.svh"

module pi_router
	import soc_pkg::*;
(
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  pi_req_t                   req_i,
	input  logic [`SOC_ARCHBITSZ-1:0] mapsz_i,
	output pi_req_t                   devtbl_req_o,
	output pi_req_t                   ram_req_o,
	input  pi_rsp_t                   devtbl_rsp_i,
	input  pi_rsp_t                   ram_rsp_i,
	output pi_rsp_t                   rsp_o
);

	localparam int OFFW = $clog2(`SOC_ARCHBITSZ/8); // Byte offset bits.

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_DEVTBL,
		TGT_RAM
	} tgt_e;

	logic [`SOC_ARCHBITSZ-1:0] byte_addr;
	logic [`SOC_ARCHBITSZ-1:0] dt_off;
	logic [`SOC_ARCHBITSZ-1:0] ram_off;
	logic                      hit_dt;
	logic                      hit_ram;
	logic                      is_read;
	tgt_e                      tgt;
	tgt_e                      tgt_q;

	assign byte_addr = {req_i.addr, {OFFW{1'b0}}};
	assign dt_off    = byte_addr - `SOC_BLOCKDEVMAPSZ;
	assign ram_off   = byte_addr - `SOC_RAM_BASE;

	// Device table sits right after the block device window.
	assign hit_ram = (byte_addr >= `SOC_RAM_BASE);
	assign hit_dt  = !hit_ram && (byte_addr >= `SOC_BLOCKDEVMAPSZ) &&
		(byte_addr < `SOC_BLOCKDEVMAPSZ + mapsz_i);
	assign is_read = (req_i.op == PI_RDOP) || (req_i.op == PI_RWOP);

	always_comb begin
		if (hit_ram)
			tgt = TGT_RAM;
		else if (hit_dt)
			tgt = TGT_DEVTBL;
		else
			tgt = TGT_NONE; // Unbacked windows.
	end

	always_comb begin
		devtbl_req_o = req_i;
		devtbl_req_o.addr = dt_off[`SOC_ARCHBITSZ-1:OFFW];
		if (tgt != TGT_DEVTBL)
			devtbl_req_o.op = PI_NOOP;
		ram_req_o = req_i;
		ram_req_o.addr = ram_off[`SOC_ARCHBITSZ-1:OFFW];
		if (tgt != TGT_RAM)
			ram_req_o.op = PI_NOOP;
	end

	// Target of last read, lines up with the data return.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			tgt_q <= TGT_NONE;
		else if (is_read)
			tgt_q <= tgt;
		else
			tgt_q <= TGT_NONE;
	end

	always_comb begin
		case (tgt_q)
			TGT_DEVTBL: rsp_o.data = devtbl_rsp_i.data;
			TGT_RAM:    rsp_o.data = ram_rsp_i.data;
			default:    rsp_o.data = '0;
		endcase
		rsp_o.rdy = devtbl_rsp_i.rdy & ram_rsp_i.rdy;
	end

	// Device table window ends at or below the RAM, so one target per address.
	a_dt_below_ram: assert property (@(posedge clk_i) disable iff (rst_i)
		`SOC_BLOCKDEVMAPSZ + mapsz_i <= `SOC_RAM_BASE);

endmodule

/* hw/devtbl.sv */
// Device table: slot descriptor readout and its own window size,
// INFO queries, and ACTION commands driving the reset requests.
`timescale 1ns/1ps
`include "soc_consts.svh"

module devtbl
	import soc_pkg::*;
(
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  pi_req_t                             req_i,
	input  dev_desc_t [`SOC_DEVMAPCNT-1:0]      dev_desc_i,
	output pi_rsp_t                             rsp_o,
	output logic [`SOC_ARCHBITSZ-1:0]           mapsz_o,
	output logic                                rst0_o,
	output logic                                rst1_o,
	output logic                                rst2_o
);

	localparam int SLOTW = $clog2(`SOC_DEVMAPCNT);
	// Space left below the first RAM device once slot 0 is placed.
	localparam logic [`SOC_ARCHBITSZ-1:0] MAPSZ_AVAIL = `SOC_RAM_BASE - `SOC_BLOCKDEVMAPSZ;

	logic [`SOC_ARCHBITSZ-1:0] mapsz_nxt;
	logic [`SOC_ARCHBITSZ-1:0] mapsz_q;
	logic                      ram_seen;
	logic [`SOC_ADDRBITSZ-2:0] slot;
	logic [SLOTW-1:0]          slot_idx;
	logic [`SOC_ARCHBITSZ-1:0] slot_mapsz;
	logic [`SOC_ARCHBITSZ-1:0] rd_data_nxt;
	logic [`SOC_ARCHBITSZ-1:0] rd_data_q;
	logic                      is_rd;
	logic                      is_info;
	logic                      is_action;
	logic                      is_rreset;
	logic                      reload_q = 1'b0; // Cleared at power-up only.

	// Own window covers everything between slot 0 and the first RAM slot.
	always_comb begin
		mapsz_nxt = MAPSZ_AVAIL;
		ram_seen = 1'b0;
		for (int i = 2; i < `SOC_DEVMAPCNT; i++) begin
			if (dev_desc_i[i].id == 1)
				ram_seen = 1'b1; // Stop at first RAM.
			if (!ram_seen)
				mapsz_nxt = mapsz_nxt - dev_desc_i[i].mapsz;
		end
	end

	always_ff @(posedge clk_i) begin
		mapsz_q <= mapsz_nxt;
	end

	assign slot      = req_i.addr[`SOC_ADDRBITSZ-1:1]; // Two words per slot.
	assign slot_idx  = slot[SLOTW-1:0];
	assign is_rd     = (req_i.op == PI_RDOP);
	assign is_info   = (req_i.op == PI_RWOP) && (req_i.addr == 0);
	assign is_action = (req_i.op == PI_RWOP) && (req_i.addr == 1);
	assign is_rreset = is_action && (req_i.data == ACT_RRESET);

	always_comb begin
		case (slot_idx)
			0:       slot_mapsz = `SOC_BLOCKDEVMAPSZ;
			1:       slot_mapsz = mapsz_q;
			default: slot_mapsz = dev_desc_i[slot_idx].mapsz;
		endcase
	end

	always_comb begin
		rd_data_nxt = '0; // ACTION and unknown reads return zero.
		if (is_rd) begin
			if (slot < `SOC_DEVMAPCNT) begin
				if (!req_i.addr[0])
					rd_data_nxt = dev_desc_i[slot_idx].id;
				else
					rd_data_nxt = {slot_mapsz[`SOC_ARCHBITSZ-1:1],
						dev_desc_i[slot_idx].useintr};
			end
		end else if (is_info) begin
			case (req_i.data)
				INFO_VERSION:    rd_data_nxt = `SOC_VERSION;
				INFO_RAMCACHESZ: rd_data_nxt = `SOC_RAMCACHESZ;
				INFO_RSTSTATE:   rd_data_nxt = {{(`SOC_ARCHBITSZ-2){1'b0}}, rst1_o, rst0_o};
				INFO_PRELDRADDR: rd_data_nxt = reload_q ? '0 : `SOC_PRELDRADDR;
				INFO_SOCID:      rd_data_nxt = `SOC_ID;
				default:         rd_data_nxt = '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (is_rd || req_i.op == PI_RWOP)
			rd_data_q <= rd_data_nxt;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
			rst2_o <= 1'b0;
		end else begin
			rst2_o <= is_rreset; // One cycle pulse.
			if (is_action) begin
				case (req_i.data)
					ACT_PWROFF: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b0;
					end
					ACT_WRESET: begin
						rst0_o <= 1'b0;
						rst1_o <= 1'b1;
					end
					ACT_CRESET: begin
						rst0_o <= 1'b1;
						rst1_o <= 1'b1;
					end
					ACT_RRESET: reload_q <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	assign rsp_o.data = rd_data_q;
	assign rsp_o.rdy  = 1'b1;
	assign mapsz_o    = mapsz_q;

	// Reset outputs stay low one cycle past reset unless an ACTION comes in.
	a_rst_outs_clear: assert property (@(posedge clk_i)
		rst_i ##1 !is_action |=> !rst0_o && !rst1_o && !rst2_o);

	a_rst2_single: assert property (@(posedge clk_i) disable iff (rst_i)
		rst2_o |=> !rst2_o);

endmodule

/* hw/ram_dev.sv */
// Word RAM used as the first RAM device.
// Byte-select writes, registered reads, address wraps at the depth.
`timescale 1ns/1ps
`include "soc_consts.svh"

module ram_dev
	import soc_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  pi_req_t req_i,
	output pi_rsp_t rsp_o
);

	localparam int IDXW = $clog2(`SOC_RAM_WORDS);
	localparam int SELW = `SOC_ARCHBITSZ / 8;

	logic [`SOC_ARCHBITSZ-1:0] mem [`SOC_RAM_WORDS];
	logic [`SOC_ARCHBITSZ-1:0] rd_data_q;
	logic [IDXW-1:0]           idx;
	logic                      wr_en;
	logic                      rd_en;

	assign idx   = req_i.addr[IDXW-1:0]; // Modulo depth.
	assign wr_en = (req_i.op == PI_WROP) || (req_i.op == PI_RWOP);
	assign rd_en = (req_i.op == PI_RDOP) || (req_i.op == PI_RWOP);

	always_ff @(posedge clk_i) begin
		for (int b = 0; b < SELW; b++) begin
			if (wr_en && req_i.sel[b])
				mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
		end
	end

	// Old word is returned on read-write.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			rd_data_q <= '0;
		else if (rd_en)
			rd_data_q <= mem[idx];
	end

	assign rsp_o.data = rd_data_q;
	assign rsp_o.rdy  = 1'b1;

endmodule

/* hw/soc_periph_top.sv */
// Peripheral subsystem top level.
// Router, device table and first RAM device.
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_periph_top
	import soc_pkg::*;
(
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  pi_req_t                        req_i,
	input  dev_desc_t [`SOC_DEVMAPCNT-1:0] dev_desc_i,
	output pi_rsp_t                        rsp_o,
	output logic                           rst0_o,
	output logic                           rst1_o,
	output logic                           rst2_o
);

	pi_req_t                   devtbl_req;
	pi_req_t                   ram_req;
	pi_rsp_t                   devtbl_rsp;
	pi_rsp_t                   ram_rsp;
	logic [`SOC_ARCHBITSZ-1:0] devtbl_mapsz; // Device table window size.

	pi_router u_router (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_i        (req_i),
		.mapsz_i      (devtbl_mapsz),
		.devtbl_req_o (devtbl_req),
		.ram_req_o    (ram_req),
		.devtbl_rsp_i (devtbl_rsp),
		.ram_rsp_i    (ram_rsp),
		.rsp_o        (rsp_o)
	);

	devtbl u_devtbl (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (devtbl_req),
		.dev_desc_i (dev_desc_i),
		.rsp_o      (devtbl_rsp),
		.mapsz_o    (devtbl_mapsz),
		.rst0_o     (rst0_o),
		.rst1_o     (rst1_o),
		.rst2_o     (rst2_o)
	);

	ram_dev u_ram (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

endmodule

/* verification/tb_soc_periph.sv */
// Self-checking testbench for the peripheral subsystem.
// Reference model of the address map, device table and RAM,
// LFSR stimulus, a response comparison process and a cycle watchdog.
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc_periph
	import soc_pkg::*;
();

	localparam logic [31:0] DT_BASE  = `SOC_BLOCKDEVMAPSZ; // Device table window start.
	localparam logic [31:0] LFSR_SEED = 32'hc765_e924;
	localparam int RT_NONE = 0;
	localparam int RT_DT   = 1;
	localparam int RT_RAM  = 2;
	// Descriptors twice, INFO, ACTION, RAM and unmapped requests.
	localparam int NUM_REQS    = 2 * 13 + 6 + 6 + 164 + 17;
	localparam int CYCLE_LIMIT = 2 * NUM_REQS + 100;

	logic                           clk_i;
	logic                           rst_i;
	pi_req_t                        req;
	dev_desc_t [`SOC_DEVMAPCNT-1:0] desc;
	pi_rsp_t                        rsp;
	logic                           rst0;
	logic                           rst1;
	logic                           rst2;

	logic [31:0] shadow_ram [`SOC_RAM_WORDS]; // RAM model.
	logic        sh_rst0;
	logic        sh_rst1;
	logic        sh_reload; // Survives rst_i.
	logic [31:0] lfsr;
	logic [31:0] exp_q[$];
	logic [31:0] addr_q[$];
	int          chk_cnt;
	int          err_cnt;
	int          test_chk0;
	int          test_err0;
	string       test_name;
	int          cycles;

	soc_periph_top UUT (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (req),
		.dev_desc_i (desc),
		.rsp_o      (rsp),
		.rst0_o     (rst0),
		.rst1_o     (rst1),
		.rst2_o     (rst2)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// RAM in slot 2, or a 1 KiB device in slot 2 and RAM in slot 3.
	function automatic dev_desc_t [`SOC_DEVMAPCNT-1:0] desc_set(input bit ram_in_slot3);
		dev_desc_t [`SOC_DEVMAPCNT-1:0] d;
		d[0] = '{id: 32'h0000_0010, mapsz: 32'd512, useintr: 1'b1};
		d[1] = '{id: 32'h0000_0020, mapsz: 32'h0, useintr: 1'b0};
		if (!ram_in_slot3) begin
			d[2] = '{id: 32'h1, mapsz: 32'h0001_0000, useintr: 1'b0};
			d[3] = '{id: 32'h5, mapsz: 32'h100, useintr: 1'b1};
		end else begin
			d[2] = '{id: 32'h7, mapsz: 32'h400, useintr: 1'b1};
			d[3] = '{id: 32'h1, mapsz: 32'h0001_0000, useintr: 1'b0};
		end
		return d;
	endfunction

	function automatic logic [31:0] calc_dt_mapsz();
		logic [31:0] sz;
		int k;
		sz = `SOC_RAM_BASE - DT_BASE;
		k = 2;
		while (k < `SOC_DEVMAPCNT && desc[k].id != 32'd1) begin
			sz = sz - desc[k].mapsz;
			k++;
		end
		return sz;
	endfunction

	function automatic int route_of(input logic [31:0] ba);
		if (ba >= `SOC_RAM_BASE)
			return RT_RAM;
		if (ba >= DT_BASE && ba < DT_BASE + calc_dt_mapsz())
			return RT_DT;
		return RT_NONE;
	endfunction

	function automatic int ram_index(input logic [31:0] ba);
		return ((ba - `SOC_RAM_BASE) >> 2) % `SOC_RAM_WORDS;
	endfunction

	function automatic logic [31:0] info_value(input logic [31:0] sel);
		case (sel)
			32'd0:   return `SOC_VERSION;
			32'd1:   return `SOC_RAMCACHESZ;
			32'd2:   return {30'b0, sh_rst1, sh_rst0};
			32'd3:   return sh_reload ? 32'h0 : `SOC_PRELDRADDR;
			32'd4:   return `SOC_ID;
			default: return 32'h0;
		endcase
	endfunction

	// Expected read data for a request, before any write takes effect.
	function automatic logic [31:0] expect_read(input pi_op_e op, input logic [31:0] ba,
		input logic [31:0] data);
		int w;
		int slot;
		logic [31:0] m;
		case (route_of(ba))
			RT_RAM: return shadow_ram[ram_index(ba)];
			RT_DT: begin
				w = (ba - DT_BASE) >> 2;
				if (op == PI_RWOP)
					return (w == 0) ? info_value(data) : 32'h0; // ACTION reads zero.
				slot = w >> 1;
				if (slot >= `SOC_DEVMAPCNT)
					return 32'h0;
				if (w % 2 == 0)
					return desc[slot].id;
				m = (slot == 0) ? `SOC_BLOCKDEVMAPSZ :
					(slot == 1) ? calc_dt_mapsz() : desc[slot].mapsz;
				return (m & ~32'h1) | {31'b0, desc[slot].useintr};
			end
			default: return 32'h0;
		endcase
	endfunction

	task automatic apply_action(input logic [31:0] cmd);
		case (cmd)
			32'd0: begin
				sh_rst0 = 1'b1;
				sh_rst1 = 1'b0;
			end
			32'd1: begin
				sh_rst0 = 1'b0;
				sh_rst1 = 1'b1;
			end
			32'd2: begin
				sh_rst0 = 1'b1;
				sh_rst1 = 1'b1;
			end
			32'd3: sh_reload = 1'b1;
			default: ;
		endcase
	endtask

	task automatic issue(input pi_op_e op, input logic [31:0] ba, input logic [31:0] data,
		input logic [3:0] sel);
		int rt;
		int idx;
		@(negedge clk_i);
		rt = route_of(ba);
		if (op == PI_RDOP || op == PI_RWOP) begin
			exp_q.push_back(expect_read(op, ba, data));
			addr_q.push_back(ba);
		end
		if (rt == RT_RAM && (op == PI_WROP || op == PI_RWOP)) begin
			idx = ram_index(ba);
			for (int b = 0; b < 4; b++) begin
				if (sel[b])
					shadow_ram[idx][8*b +: 8] = data[8*b +: 8];
			end
		end
		if (rt == RT_DT && op == PI_RWOP && ba == DT_BASE + 4)
			apply_action(data);
		req.op   = op;
		req.addr = ba[31:2];
		req.data = data;
		req.sel  = sel;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk_i);
			req.op = PI_NOOP;
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		chk_cnt++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_chk0 = chk_cnt;
		test_err0 = err_cnt;
	endtask

	task automatic end_test();
		idle(2); // Lets the last response be compared.
		assert (exp_q.size() == 0) else begin
			$display("ERROR at %0t: %0d expected responses never arrived", $time, exp_q.size());
			err_cnt++;
		end
		$display("%s: %0d checks, %0d errors", test_name, chk_cnt - test_chk0,
			err_cnt - test_err0);
	endtask

	task automatic load_descs(input bit ram_in_slot3);
		@(negedge clk_i);
		req.op = PI_NOOP;
		desc = desc_set(ram_in_slot3);
		@(negedge clk_i); // Window size is registered.
	endtask

	task automatic test_descriptors(input string tag);
		begin_test({"descriptors ", tag});
		for (int w = 0; w < 2 * `SOC_DEVMAPCNT + 2; w++)
			issue(PI_RDOP, DT_BASE + 4 * w, 32'h0, 4'h0);
		end_test();
	endtask

	task automatic test_mapsz(input string tag);
		begin_test({"map size ", tag});
		issue(PI_RDOP, DT_BASE + 12, 32'h0, 4'h0); // Own mapsz word.
		issue(PI_RDOP, DT_BASE, 32'h0, 4'h0);
		issue(PI_RDOP, DT_BASE + calc_dt_mapsz() - 4, 32'h0, 4'h0);
		end_test();
	endtask

	task automatic test_info();
		begin_test("INFO");
		for (int s = 0; s < 5; s++)
			issue(PI_RWOP, DT_BASE, s, 4'h0);
		issue(PI_RWOP, DT_BASE, 32'h9, 4'h0); // Unknown selector.
		end_test();
	endtask

	task automatic do_action(input logic [31:0] cmd, input logic e0, input logic e1);
		issue(PI_RWOP, DT_BASE + 4, cmd, 4'h0);
		idle(1);
		check_val("rst0_o", e0, rst0);
		check_val("rst1_o", e1, rst1);
		check_val("rst2_o", 1'b0, rst2);
	endtask

	task automatic test_action();
		begin_test("ACTION");
		do_action(ACT_PWROFF, 1'b1, 1'b0);
		do_action(ACT_WRESET, 1'b0, 1'b1);
		do_action(ACT_CRESET, 1'b1, 1'b1);
		issue(PI_RWOP, DT_BASE + 4, ACT_RRESET, 4'h0);
		idle(1);
		check_val("rst2_o", 1'b1, rst2);
		idle(1);
		check_val("rst2_o", 1'b0, rst2);
		check_val("rst0_o", 1'b1, rst0);
		check_val("rst1_o", 1'b1, rst1);
		issue(PI_RWOP, DT_BASE, INFO_RSTSTATE, 4'h0);
		issue(PI_RWOP, DT_BASE, INFO_PRELDRADDR, 4'h0);
		end_test();
	endtask

	task automatic test_ram();
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0]  s;
		begin_test("RAM");
		for (int i = 0; i < `SOC_RAM_WORDS; i++)
			issue(PI_WROP, `SOC_RAM_BASE + 4 * i, rand_bits(32), 4'hf);
		for (int i = 0; i < 24; i++) begin
			a = `SOC_RAM_BASE + 4 * rand_bits(6);
			d = rand_bits(32);
			s = rand_bits(4);
			issue(PI_WROP, a, d, s);
		end
		for (int i = 0; i < `SOC_RAM_WORDS; i++)
			issue(PI_RDOP, `SOC_RAM_BASE + 4 * i, 32'h0, 4'h0);
		for (int i = 0; i < 4; i++)
			issue(PI_RDOP, `SOC_RAM_BASE + 32'h100 * (i + 1) + 4 * i, 32'h0, 4'h0); // Wraps.
		for (int i = 0; i < 4; i++) begin
			a = `SOC_RAM_BASE + 4 * rand_bits(6);
			d = rand_bits(32);
			s = rand_bits(4);
			issue(PI_RWOP, a, d, s); // Returns the old word.
			issue(PI_RDOP, a, 32'h0, 4'h0);
		end
		end_test();
	endtask

	task automatic test_unmapped();
		begin_test("unmapped");
		issue(PI_RDOP, 32'h0, 32'h0, 4'h0);
		issue(PI_RDOP, 32'h100, 32'h0, 4'h0);
		issue(PI_RDOP, 32'h1fc, 32'h0, 4'h0);
		issue(PI_RDOP, 32'hc00, 32'h0, 4'h0); // Slot 2 window.
		issue(PI_RDOP, 32'hffc, 32'h0, 4'h0);
		issue(PI_RWOP, 32'h10, 32'h1234_5678, 4'hf);
		issue(PI_RWOP, 32'hc04, 32'h1234_5678, 4'hf);
		issue(PI_WROP, 32'h0, 32'hdead_beef, 4'hf);
		issue(PI_WROP, 32'hc00, 32'hdead_beef, 4'hf);
		for (int i = 0; i < 8; i++)
			issue(PI_RDOP, `SOC_RAM_BASE + 4 * i, 32'h0, 4'h0);
		end_test();
	endtask

	// Checks each accepted read one cycle later.
	always @(posedge clk_i) begin : compare_rsp
		logic [31:0] exp_data;
		logic [31:0] exp_addr;
		if (!rst_i && (req.op == PI_RDOP || req.op == PI_RWOP)) begin
			assert (exp_q.size() > 0) else begin
				$display("ERROR at %0t: read accepted with no expected value queued", $time);
				err_cnt++;
			end
			if (exp_q.size() > 0) begin
				exp_data = exp_q.pop_front();
				exp_addr = addr_q.pop_front();
				@(negedge clk_i);
				check_val($sformatf("rsp_o.data[%h]", exp_addr), exp_data, rsp.data);
				check_val("rsp_o.rdy", 32'h1, {31'b0, rsp.rdy}); // Always ready.
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		rst_i     = 1'b1;
		req       = '0;
		desc      = desc_set(1'b0);
		lfsr      = LFSR_SEED;
		sh_rst0   = 1'b0;
		sh_rst1   = 1'b0;
		sh_reload = 1'b0;
		chk_cnt   = 0;
		err_cnt   = 0;
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		load_descs(1'b0);
		test_descriptors("set A");
		test_mapsz("set A");
		test_info();
		test_action();
		test_ram();
		load_descs(1'b1);
		test_descriptors("set B");
		test_mapsz("set B");
		test_unmapped();

		$display("Total: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+hw
hw/soc_pkg.sv
hw/pi_router.sv
hw/devtbl.sv
hw/ram_dev.sv
hw/soc_periph_top.sv
verification/tb_soc_periph.sv
